/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Widths
    ///////////////////////////////////////////////////////////////////////

    // Datapath word
    localparam int word_w = 32;
    // Register index, enough for x0..x31
    localparam int reg_addr_w = 5;

    typedef logic [word_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    ///////////////////////////////////////////////////////////////////////
    // Operation encodings
    ///////////////////////////////////////////////////////////////////////

    // ALU operations, RISC-V semantics
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        SLT  = 4'd8,
        SLTU = 4'd9
    } alu_op_e;

    // What the instruction does after EX
    typedef enum logic [1:0] {
        ALU    = 2'd0,
        STORE  = 2'd1,
        BRANCH = 2'd2
    } kind_e;

    // Branch condition, tested against the ALU zero flag
    typedef enum logic [1:0] {
        BEQ = 2'd0,
        BNE = 2'd1,
        BLT = 2'd2,
        BGE = 2'd3
    } branch_e;

    // Store width
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } size_e;

    // Operand source for the forwarding muxes
    typedef enum logic [1:0] {
        REGFILE  = 2'b00,
        FROM_WB  = 2'b01,
        FROM_MEM = 2'b10
    } fwd_sel_e;

    ///////////////////////////////////////////////////////////////////////
    // Stage records
    ///////////////////////////////////////////////////////////////////////

    // Decoded instruction at issue
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        alu_op_e   alu_op;
        // 1 selects imm as operand 2
        logic      alu_src;
        kind_e     kind;
        branch_e   cond;
        size_e     size;
    } issue_t;

    // ID/EX contents
    typedef struct packed {
        issue_t ins;
        word_t  data1;
        word_t  data2;
    } idex_t;

    // EX/MEM contents
    typedef struct packed {
        logic      valid;
        kind_e     kind;
        reg_addr_t rd;
        logic      reg_write;
        word_t     result;
        word_t     save_data;
        size_e     size;
        logic      taken;
        word_t     target;
    } exmem_t;

    // MEM/WB contents and the register-file write port
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
        word_t data;
        size_e size;
    } store_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        word_t target;
    } branch_t;

endpackage

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  ex_pkg::reg_addr_t raddr1,
    input  ex_pkg::reg_addr_t raddr2,
    output ex_pkg::word_t     rdata1,
    output ex_pkg::word_t     rdata2,
    input  ex_pkg::wb_t       wb
);

    import ex_pkg::*;

    // Storage, x0 included but never written
    word_t regs [NUM_REGS];

    // Write is accepted only for an implemented nonzero register
    logic wr_en;

    assign wr_en = wb.valid && (wb.rd != '0) && (int'(wb.rd) < NUM_REGS);

    ///////////////////////////////////////////////////////////////////////
    // Read ports
    ///////////////////////////////////////////////////////////////////////

    function automatic word_t read_port(input reg_addr_t addr);
        word_t val;
        // x0 and unimplemented registers
        if ((addr == '0) || (int'(addr) >= NUM_REGS)) begin
            val = '0;
        // Same-cycle write goes straight through
        end else if (wr_en && (wb.rd == addr)) begin
            val = wb.value;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    assign rdata1 = read_port(raddr1);
    assign rdata2 = read_port(raddr2);

    ///////////////////////////////////////////////////////////////////////
    // Write port
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.value;
        end
    end

endmodule

`default_nettype wire

/* forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  ex_pkg::reg_addr_t rs1,
    input  ex_pkg::reg_addr_t rs2,
    input  ex_pkg::reg_addr_t mem_rd,
    input  logic              mem_write,
    input  ex_pkg::wb_t       wb_in,
    output ex_pkg::fwd_sel_e  sel1,
    output ex_pkg::fwd_sel_e  sel2
);

    import ex_pkg::*;

    // Producer one instruction ahead, sitting in EX/MEM
    logic mem_hit_ok;
    // Producer two instructions ahead, sitting in MEM/WB
    logic wb_hit_ok;

    // x0 is never a forwarding source
    assign mem_hit_ok = mem_write && (mem_rd != '0);
    assign wb_hit_ok  = wb_in.valid && (wb_in.rd != '0);

    // Newest producer wins
    function automatic fwd_sel_e pick(input reg_addr_t rs);
        fwd_sel_e sel;
        if (mem_hit_ok && (mem_rd == rs)) begin
            sel = FROM_MEM;
        end else if (wb_hit_ok && (wb_in.rd == rs)) begin
            sel = FROM_WB;
        end else begin
            // Older results already in the array or bypassed there
            sel = REGFILE;
        end
        return sel;
    endfunction

    assign sel1 = pick(rs1);
    assign sel2 = pick(rs2);

endmodule

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  ex_pkg::word_t   a,
    input  ex_pkg::word_t   b,
    input  ex_pkg::alu_op_e op,
    output ex_pkg::word_t   result,
    output logic            zero
);

    import ex_pkg::*;

    // Shift amount from the low five bits of b
    logic [4:0] shamt;

    assign shamt = b[4:0];

    ///////////////////////////////////////////////////////////////////////
    // Operation select
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            ADD: begin
                result = a + b;
            end
            SUB: begin
                result = a - b;
            end
            AND: begin
                result = a & b;
            end
            OR: begin
                result = a | b;
            end
            XOR: begin
                result = a ^ b;
            end
            SLL: begin
                result = a << shamt;
            end
            SRL: begin
                result = a >> shamt;
            end
            SRA: begin
                // Sign bit fills from the left
                result = word_t'($signed(a) >>> shamt);
            end
            SLT: begin
                // Signed compare, 1 or 0
                result = word_t'($signed(a) < $signed(b));
            end
            SLTU: begin
                result = word_t'(a < b);
            end
            default: begin
                // Unused encodings
                result = '0;
            end
        endcase
    end

    // Branches key off this
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  ex_pkg::idex_t    idex,
    input  ex_pkg::fwd_sel_e sel1,
    input  ex_pkg::fwd_sel_e sel2,
    input  ex_pkg::word_t    mem_forward,
    input  ex_pkg::word_t    wb_forward,
    output ex_pkg::exmem_t   exmem
);

    import ex_pkg::*;

    // Forwarded register values
    word_t rs1_val;
    word_t rs2_val;
    // ALU operands
    word_t op_a;
    word_t op_b;
    // ALU outputs
    word_t alu_result;
    logic  alu_zero;
    // Branch decision
    logic  cond_met;

    ///////////////////////////////////////////////////////////////////////
    // Operand selection
    ///////////////////////////////////////////////////////////////////////

    // Three-way forwarding mux
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        word_t val;
        case (sel)
            FROM_MEM: begin
                val = mem_forward;
            end
            FROM_WB: begin
                val = wb_forward;
            end
            default: begin
                val = reg_val;
            end
        endcase
        return val;
    endfunction

    assign rs1_val = fwd_mux(sel1, idex.data1);
    assign rs2_val = fwd_mux(sel2, idex.data2);

    assign op_a = rs1_val;
    // Immediate or register for operand 2
    assign op_b = idex.ins.alu_src ? idex.ins.imm : rs2_val;

    alu alu0 (
        .a      (op_a),
        .b      (op_b),
        .op     (idex.ins.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    ///////////////////////////////////////////////////////////////////////
    // Branch resolution
    ///////////////////////////////////////////////////////////////////////

    // SUB feeds BEQ/BNE, SLT feeds BLT/BGE
    always_comb begin
        case (idex.ins.cond)
            BEQ: begin
                cond_met = alu_zero;
            end
            BNE: begin
                cond_met = !alu_zero;
            end
            BLT: begin
                cond_met = !alu_zero;
            end
            default: begin
                // BGE
                cond_met = alu_zero;
            end
        endcase
    end

    ///////////////////////////////////////////////////////////////////////
    // EX/MEM record
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        exmem.valid     = idex.ins.valid;
        exmem.kind      = idex.ins.kind;
        exmem.rd        = idex.ins.rd;
        // Only ALU results go back to a real register
        exmem.reg_write = idex.ins.valid && (idex.ins.kind == ALU) && (idex.ins.rd != '0);
        // Also the store address
        exmem.result    = alu_result;
        exmem.save_data = rs2_val;
        exmem.size      = idex.ins.size;
        exmem.taken     = (idex.ins.kind == BRANCH) && cond_met;
        // Target adder
        exmem.target    = idex.ins.pc + idex.ins.imm;
    end

endmodule

`default_nettype wire

/* exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter int NUM_REGS = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  ex_pkg::issue_t  issue,
    output ex_pkg::wb_t     wb_out,
    output ex_pkg::store_t  store_out,
    output ex_pkg::branch_t branch_out
);

    import ex_pkg::*;

    // Register-file read data in the issue cycle
    word_t rdata1;
    word_t rdata2;

    // Pipeline register inputs and outputs
    idex_t  idex_d;
    idex_t  idex_q;
    exmem_t exmem_d;
    exmem_t exmem_q;
    wb_t    wb_d;
    wb_t    wb_q;

    // Forwarding selects for the EX operands
    fwd_sel_e sel1;
    fwd_sel_e sel2;

    ///////////////////////////////////////////////////////////////////////
    // Issue and register read
    ///////////////////////////////////////////////////////////////////////

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) reg_file0 (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (issue.rs1),
        .raddr2 (issue.rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb_q)
    );

    always_comb begin
        idex_d.ins   = issue;
        idex_d.data1 = rdata1;
        idex_d.data2 = rdata2;
    end

    // ID/EX, only valid is cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            idex_q.ins.valid <= 1'b0;
        end else begin
            idex_q <= idex_d;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Execute
    ///////////////////////////////////////////////////////////////////////

    // Producers one and two ahead
    forward_unit forward_unit0 (
        .rs1       (idex_q.ins.rs1),
        .rs2       (idex_q.ins.rs2),
        .mem_rd    (exmem_q.rd),
        .mem_write (exmem_q.reg_write),
        .wb_in     (wb_q),
        .sel1      (sel1),
        .sel2      (sel2)
    );

    ex_stage ex_stage0 (
        .idex        (idex_q),
        .sel1        (sel1),
        .sel2        (sel2),
        .mem_forward (exmem_q.result),
        .wb_forward  (wb_q.value),
        .exmem       (exmem_d)
    );

    // EX/MEM, valid and write enable are control
    always_ff @(posedge clk) begin
        if (rst) begin
            exmem_q.valid     <= 1'b0;
            exmem_q.reg_write <= 1'b0;
        end else begin
            exmem_q <= exmem_d;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // MEM and writeback
    ///////////////////////////////////////////////////////////////////////

    // No data memory so the result moves straight on
    always_comb begin
        wb_d.valid = exmem_q.reg_write;
        wb_d.rd    = exmem_q.rd;
        wb_d.value = exmem_q.result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q <= wb_d;
        end
    end

    assign wb_out = wb_q;

    // Store request out of EX/MEM
    always_comb begin
        store_out.valid = exmem_q.valid && (exmem_q.kind == STORE);
        store_out.addr  = exmem_q.result;
        store_out.data  = exmem_q.save_data;
        store_out.size  = exmem_q.size;
    end

    // Branch resolution out of EX/MEM, caller redirects
    always_comb begin
        branch_out.valid  = exmem_q.valid && (exmem_q.kind == BRANCH);
        branch_out.taken  = exmem_q.taken;
        branch_out.target = exmem_q.target;
    end

endmodule

`default_nettype wire

/* tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

    import ex_pkg::*;

    ///////////////////////////////////////////////////////////////////////
    // Run length
    ///////////////////////////////////////////////////////////////////////

    localparam int num_regs     = 32;
    localparam int n_seed       = 31;
    localparam int n_alu        = 60;
    localparam int n_store      = 20;
    localparam int n_branch     = 64;
    localparam int n_dep        = 200;
    localparam int n_gap        = 150;
    localparam int n_pre_reset  = 8;
    localparam int n_post_reset = 40;
    localparam int n_drain      = 8;
    localparam int total_slots  = n_seed + n_alu + n_store + n_branch + n_dep + n_gap
                                  + n_pre_reset + n_post_reset + n_drain;
    // Each issue slot is one 4 ns cycle
    localparam int watchdog_ns  = total_slots * 4 + 200;

    logic    clk;
    logic    rst;
    issue_t  issue;
    wb_t     wb_out;
    store_t  store_out;
    branch_t branch_out;
    // DUT has taken at least one reset edge
    logic    rst_seen = 1'b0;

    // Architectural state in program order
    word_t model_regs [num_regs];

    // One expectation queue per output
    wb_t     exp_wb_q[$];
    store_t  exp_store_q[$];
    branch_t exp_branch_q[$];

    exec_core #(
        .NUM_REGS (num_regs)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .wb_out     (wb_out),
        .store_out  (store_out),
        .branch_out (branch_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) rst_seen <= rst;

    ///////////////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    ///////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "error: %0d ns: writeback rd=%0d value=%h, expected rd=%0d value=%h",
                $time, got.rd, got.value, exp.rd, exp.value));
        end
    endtask

    task automatic check_store(input store_t got, input store_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "error: %0d ns: store addr=%h data=%h size=%0d, exp addr=%h data=%h size=%0d",
                $time, got.addr, got.data, got.size, exp.addr, exp.data, exp.size));
        end
    endtask

    task automatic check_branch(input branch_t got, input branch_t exp);
        if (got !== exp) begin
            report_failure($sformatf(
                "error: %0d ns: branch taken=%0b target=%h, expected taken=%0b target=%h",
                $time, got.taken, got.target, exp.taken, exp.target));
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Reference model
    ///////////////////////////////////////////////////////////////////////

    // RISC-V integer semantics
    function automatic word_t alu_ref(input alu_op_e op, input word_t a, input word_t b);
        word_t r;
        case (op)
            ADD:     r = a + b;
            SUB:     r = a - b;
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SLL:     r = a << b[4:0];
            SRL:     r = a >> b[4:0];
            SRA:     r = $signed(a) >>> b[4:0];
            SLT:     r = {31'b0, $signed(a) < $signed(b)};
            SLTU:    r = {31'b0, a < b};
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic void model_exec(input issue_t ins, output wb_t w,
                                       output store_t s, output branch_t b);
        word_t a;
        word_t r2;
        word_t res;
        w = '0;
        s = '0;
        b = '0;
        if (!ins.valid) return;
        a   = model_regs[ins.rs1];
        r2  = model_regs[ins.rs2];
        res = alu_ref(ins.alu_op, a, ins.alu_src ? ins.imm : r2);
        case (ins.kind)
            ALU: begin
                // x0 stays zero and is never reported
                if (ins.rd != '0) begin
                    model_regs[ins.rd] = res;
                    w.valid = 1'b1;
                    w.rd    = ins.rd;
                    w.value = res;
                end
            end
            STORE: begin
                s.valid = 1'b1;
                s.addr  = a + ins.imm;
                s.data  = r2;
                s.size  = ins.size;
            end
            default: begin
                b.valid  = 1'b1;
                b.target = ins.pc + ins.imm;
                case (ins.cond)
                    BEQ:     b.taken = (a == r2);
                    BNE:     b.taken = (a != r2);
                    BLT:     b.taken = ($signed(a) < $signed(r2));
                    default: b.taken = ($signed(a) >= $signed(r2));
                endcase
            end
        endcase
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ///////////////////////////////////////////////////////////////////////

    function automatic reg_addr_t rand_reg(input int lo, input int hi);
        return reg_addr_t'($urandom_range(lo, hi));
    endfunction

    // ALU instruction with random sources in x1..x31
    function automatic issue_t alu_ins(input alu_op_e op, input logic src, input reg_addr_t rd);
        issue_t ins;
        ins         = '0;
        ins.valid   = 1'b1;
        ins.pc      = $urandom() & 32'hffff_fffc;
        ins.rs1     = rand_reg(1, num_regs - 1);
        ins.rs2     = rand_reg(1, num_regs - 1);
        ins.rd      = rd;
        ins.imm     = $urandom();
        ins.alu_op  = op;
        ins.alu_src = src;
        ins.kind    = ALU;
        return ins;
    endfunction

    function automatic issue_t branch_ins(input branch_e cond, input int span);
        issue_t ins;
        ins         = alu_ins(SUB, 1'b0, rand_reg(0, span - 1));
        ins.rs1     = rand_reg(0, span - 1);
        ins.rs2     = rand_reg(0, span - 1);
        ins.kind    = BRANCH;
        ins.cond    = cond;
        // SUB for equality, SLT for ordering
        ins.alu_op  = ((cond == BEQ) || (cond == BNE)) ? SUB : SLT;
        return ins;
    endfunction

    function automatic issue_t store_ins(input int span);
        issue_t ins;
        ins         = alu_ins(ADD, 1'b1, rand_reg(0, span - 1));
        ins.rs1     = rand_reg(0, span - 1);
        ins.rs2     = rand_reg(0, span - 1);
        ins.kind    = STORE;
        ins.size    = size_e'($urandom_range(0, 2));
        return ins;
    endfunction

    // Mix of kinds over registers 0..span-1
    function automatic issue_t random_ins(input int span);
        issue_t ins;
        int     pick;
        pick = $urandom_range(0, 9);
        if (pick < 6) begin
            ins     = alu_ins(alu_op_e'($urandom_range(0, 9)), 1'($urandom_range(0, 1)),
                              rand_reg(0, span - 1));
            ins.rs1 = rand_reg(0, span - 1);
            ins.rs2 = rand_reg(0, span - 1);
        end else if (pick < 8) begin
            ins = store_ins(span);
        end else begin
            ins = branch_ins(branch_e'($urandom_range(0, 3)), span);
        end
        return ins;
    endfunction

    // One issue slot with its expectation pushed in program order
    task automatic drive_slot(input issue_t ins);
        wb_t     w;
        store_t  s;
        branch_t b;
        @(posedge clk);
        issue <= ins;
        model_exec(ins, w, s, b);
        if (w.valid) exp_wb_q.push_back(w);
        if (s.valid) exp_store_q.push_back(s);
        if (b.valid) exp_branch_q.push_back(b);
    endtask

    // Reset with instructions still in flight
    task automatic apply_reset();
        @(posedge clk);
        rst   <= 1'b1;
        issue <= '0;
        exp_wb_q.delete();
        exp_store_q.delete();
        exp_branch_q.delete();
        for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Compare process and watchdog
    ///////////////////////////////////////////////////////////////////////

    initial begin
        forever begin
            @(negedge clk);
            if (rst) begin
                if (rst_seen && ((wb_out.valid !== 1'b0) || (store_out.valid !== 1'b0)
                                 || (branch_out.valid !== 1'b0))) begin
                    report_failure("An output was valid while reset was held");
                end
            end else begin
                if (wb_out.valid) begin
                    if (exp_wb_q.size() == 0) begin
                        report_failure("Writeback appeared with none expected");
                    end else begin
                        check_wb(wb_out, exp_wb_q.pop_front());
                    end
                end
                if (store_out.valid) begin
                    if (exp_store_q.size() == 0) begin
                        report_failure("Store appeared with none expected");
                    end else begin
                        check_store(store_out, exp_store_q.pop_front());
                    end
                end
                if (branch_out.valid) begin
                    if (exp_branch_q.size() == 0) begin
                        report_failure("Branch appeared with none expected");
                    end else begin
                        check_branch(branch_out, exp_branch_q.pop_front());
                    end
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        report_failure("Timeout, the run did not finish within the watchdog limit");
    end

    ///////////////////////////////////////////////////////////////////////
    // Test sequence
    ///////////////////////////////////////////////////////////////////////

    initial begin
        issue_t ins;
        void'($urandom(32'h9e65));
        for (int i = 0; i < num_regs; i++) model_regs[i] = '0;
        rst   = 1'b1;
        issue = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // Seed x1..x31 from x0 plus imm
        for (int i = 1; i <= n_seed; i++) begin
            ins     = alu_ins(ADD, 1'b1, reg_addr_t'(i));
            ins.rs1 = '0;
            drive_slot(ins);
        end
        // Every op in register and imm form with the last write to x0
        for (int op = 0; op < 10; op++) begin
            for (int src = 0; src < 2; src++) begin
                for (int j = 0; j < 3; j++) begin
                    drive_slot(alu_ins(alu_op_e'(op), 1'(src),
                                       (j == 2) ? reg_addr_t'(0) : rand_reg(1, num_regs - 1)));
                end
            end
        end
        for (int i = 0; i < n_store; i++) drive_slot(store_ins(num_regs));
        // Producer right before each branch on x0..x3
        for (int c = 0; c < 4; c++) begin
            for (int j = 0; j < n_branch / 8; j++) begin
                ins     = alu_ins(alu_op_e'($urandom_range(0, 9)), 1'b0, rand_reg(1, 3));
                ins.rs1 = rand_reg(0, 3);
                ins.rs2 = rand_reg(0, 3);
                drive_slot(ins);
                drive_slot(branch_ins(branch_e'(c), 4));
            end
        end
        // Dense dependencies at distance 1, 2 and 3
        for (int i = 0; i < n_dep; i++) drive_slot(random_ins(4));
        // Bubbles mixed in
        for (int i = 0; i < n_gap; i++) begin
            ins = random_ins(num_regs);
            // Invalid slot still carries a full instruction
            if ($urandom_range(0, 9) < 3) ins.valid = 1'b0;
            drive_slot(ins);
        end

        for (int i = 0; i < n_pre_reset; i++) drive_slot(random_ins(num_regs));
        apply_reset();
        // Cleared registers must read zero
        ins     = alu_ins(ADD, 1'b0, reg_addr_t'(5));
        ins.rs1 = reg_addr_t'(7);
        ins.rs2 = reg_addr_t'(9);
        drive_slot(ins);
        for (int i = 1; i < n_post_reset; i++) drive_slot(random_ins(num_regs));

        for (int i = 0; i < n_drain; i++) drive_slot('0);
        @(negedge clk);
        if ((exp_wb_q.size() != 0) || (exp_store_q.size() != 0)
                || (exp_branch_q.size() != 0)) begin
            report_failure("Expected outputs never appeared before the end of the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
ex_pkg.sv
reg_file.sv
forward_unit.sv
alu.sv
ex_stage.sv
exec_core.sv
tb_exec_core.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - ex_pkg.sv
  - reg_file.sv
  - forward_unit.sv
  - alu.sv
  - ex_stage.sv
  - exec_core.sv
  - target: simulation
    files:
      - tb_exec_core.sv
